// File: conv_core.f
+incdir+rtl
rtl/cnn_pkg.sv
rtl/n_delay.sv
rtl/proc_engine.sv
rtl/beat_sequencer.sv
rtl/column_serializer.sv
rtl/conv_core.sv
dv/conv_core_tb.sv

// File: dv/conv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_core_tb;

  localparam int COLS     = `COLS;
  localparam int ROWS     = `ROWS;
  localparam int Y_BITS   = `Y_BITS;
  localparam int COL_BITS = $clog2(`COLS);
  localparam int N_SETS   = 12;
  localparam logic [31:0] SEED = 32'he9f8_11f1;

  logic                         clk;
  logic                         resetn;
  logic                         cfg_start;
  logic [`KW2_BITS-1:0]         cfg_kw2;
  logic [`CIN_BITS-1:0]         cfg_cin;
  logic                         in_valid;
  logic                         in_ready;
  logic                         in_last;
  logic [ROWS-1:0][`X_BITS-1:0] in_pixels;
  logic [COLS-1:0][`K_BITS-1:0] in_weights;
  logic                         out_ready;
  logic                         out_valid;
  logic                         out_last;
  logic [COL_BITS-1:0]          out_col;
  logic [ROWS-1:0][Y_BITS-1:0]  out_data;

  logic [31:0] stim_state;
  logic [31:0] ready_state;
  int set_kw2[N_SETS];
  int set_cin[N_SETS];
  int set_groups[N_SETS];
  int total_beats;
  int cycle_limit;
  int cycles;

  // One expected output beat per column
  logic [ROWS-1:0][Y_BITS-1:0] exp_data_q[$];
  logic [COL_BITS-1:0]         exp_col_q[$];
  logic                        exp_last_q[$];

  // Beat seen stalled on the previous falling edge
  logic                        hold_pending;
  logic [ROWS-1:0][Y_BITS-1:0] hold_data;
  logic [COL_BITS-1:0]         hold_col;
  logic                        hold_last;

  conv_core conv_core_i (
    .clk(clk), .resetn(resetn),
    .cfg_start(cfg_start), .cfg_kw2(cfg_kw2), .cfg_cin(cfg_cin),
    .in_valid(in_valid), .in_ready(in_ready), .in_last(in_last),
    .in_pixels(in_pixels), .in_weights(in_weights),
    .out_ready(out_ready), .out_valid(out_valid), .out_last(out_last),
    .out_col(out_col), .out_data(out_data)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int stim_rand(input int range);
    stim_state = lcg_step(stim_state);
    return int'(stim_state[30:16]) % range;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input logic signed [Y_BITS-1:0] got,
                            input logic signed [Y_BITS-1:0] exp, input int row);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: out_data[%0d] got %0d expected %0d", $time, row, got, exp);
      abort_run("output data mismatch");
    end
  endtask

  task automatic check_col(input logic [COL_BITS-1:0] got, input logic [COL_BITS-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: out_col got %0d expected %0d", $time, got, exp);
      abort_run("output column out of order");
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: out_last got %0b expected %0b", $time, got, exp);
      abort_run("out_last on the wrong beat");
    end
  endtask

  task automatic take_output();
    logic [ROWS-1:0][Y_BITS-1:0] exp_data;
    logic [COL_BITS-1:0] exp_col;
    logic exp_last;
    if (exp_col_q.size() == 0) begin
      abort_run("output beat arrived with no result expected");
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_col  = exp_col_q.pop_front();
      exp_last = exp_last_q.pop_front();
      for (int r = 0; r < ROWS; r++) begin
        check_data(out_data[r], exp_data[r], r);
      end
      check_col(out_col, exp_col);
      check_last(out_last, exp_last);
    end
  endtask

  task automatic send_beat(input logic [ROWS-1:0][`X_BITS-1:0] pix,
                           input logic [COLS-1:0][`K_BITS-1:0] wgt, input logic last);
    in_pixels  = pix;
    in_weights = wgt;
    in_last    = last;
    in_valid   = 1'b1;
    while (!in_ready) begin
      @(negedge clk);
    end
    // Transfer happens on the rising edge in between
    @(negedge clk);
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic run_set(input int s);
    logic signed [Y_BITS-1:0] psum[COLS][ROWS];
    logic signed [Y_BITS-1:0] prev[COLS][ROWS];
    logic signed [Y_BITS-1:0] res[COLS][ROWS];
    logic [ROWS-1:0][`X_BITS-1:0] pix;
    logic [COLS-1:0][`K_BITS-1:0] wgt;
    logic [ROWS-1:0][Y_BITS-1:0] beat;
    int kw2;
    int span;
    kw2  = set_kw2[s];
    span = 2 * kw2 + 1;
    @(negedge clk);
    cfg_start = 1'b1;
    cfg_kw2   = `KW2_BITS'(kw2);
    cfg_cin   = `CIN_BITS'(set_cin[s]);
    @(negedge clk);
    cfg_start = 1'b0;
    for (int g = 0; g < set_groups[s]; g++) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          psum[c][r] = '0;
        end
      end
      for (int b = 0; b < set_cin[s]; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          pix[r] = `X_BITS'(stim_rand(256));
        end
        for (int c = 0; c < COLS; c++) begin
          wgt[c] = `K_BITS'(stim_rand(256));
        end
        for (int c = 0; c < COLS; c++) begin
          for (int r = 0; r < ROWS; r++) begin
            psum[c][r] = psum[c][r] + Y_BITS'($signed(pix[r])) * Y_BITS'($signed(wgt[c]));
          end
        end
        // Occasional idle cycles on the input
        if (stim_rand(4) == 0) begin
          repeat (1 + stim_rand(3)) @(negedge clk);
        end
        send_beat(pix, wgt, (g == set_groups[s] - 1) && (b == set_cin[s] - 1));
      end
      // Carry comes from the left neighbour's previous result
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          if (g != 0 && kw2 != 0 && (c % span) != 0) begin
            res[c][r] = psum[c][r] + prev[c-1][r];
          end else begin
            res[c][r] = psum[c][r];
          end
          beat[r] = res[c][r];
        end
        exp_data_q.push_back(beat);
        exp_col_q.push_back(COL_BITS'(c));
        exp_last_q.push_back((g == set_groups[s] - 1) && (c == COLS - 1));
      end
      prev = res;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles with results still missing", cycles));
    end
  end

  // Output side with random back-pressure
  always @(negedge clk) begin
    if (resetn) begin
      if (hold_pending) begin
        if (!out_valid) begin
          abort_run("out_valid dropped before the stalled beat was taken");
        end
        for (int r = 0; r < ROWS; r++) begin
          check_data(out_data[r], hold_data[r], r);
        end
        check_col(out_col, hold_col);
        check_last(out_last, hold_last);
      end
      ready_state  = lcg_step(ready_state);
      out_ready    = (ready_state[29:28] != 2'b00);
      hold_pending = out_valid && !out_ready;
      hold_data    = out_data;
      hold_col     = out_col;
      hold_last    = out_last;
      if (out_valid && out_ready) begin
        take_output();
      end
    end
  end

  initial begin
    stim_state   = SEED;
    ready_state  = ~SEED;
    resetn       = 1'b0;
    cfg_start    = 1'b0;
    cfg_kw2      = '0;
    cfg_cin      = '0;
    in_valid     = 1'b0;
    in_last      = 1'b0;
    in_pixels    = '0;
    in_weights   = '0;
    out_ready    = 1'b0;
    hold_pending = 1'b0;
    cycles       = 0;
    total_beats  = 0;
    // First sets plain and later ones mix half-widths
    for (int s = 0; s < N_SETS; s++) begin
      set_kw2[s]    = (s < 3) ? 0 : ((s % 2 == 1) ? 1 : stim_rand(2));
      set_cin[s]    = 1 + stim_rand(6);
      set_groups[s] = (set_kw2[s] != 0) ? 2 + stim_rand(3) : 1 + stim_rand(3);
      total_beats   = total_beats + set_cin[s] * set_groups[s];
    end
    cycle_limit = 40 * total_beats + 1000;
    repeat (5) @(posedge clk);
    @(negedge clk);
    resetn <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (in_ready || out_valid) begin
        abort_run("in_ready or out_valid went high before the first cfg_start");
      end
    end
    for (int s = 0; s < N_SETS; s++) begin
      run_set(s);
    end
    while (exp_col_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    if (out_valid) begin
      abort_run("extra output beat after all results were taken");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: rtl/beat_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module beat_sequencer (
  input  wire logic                          clk,
  input  wire logic                          resetn,
  input  wire logic                          cfg_start,
  input  wire logic [`KW2_BITS-1:0]          cfg_kw2,
  input  wire logic [`CIN_BITS-1:0]          cfg_cin,
  input  wire logic                          in_valid,
  input  wire logic                          in_last,
  input  wire logic [`ROWS-1:0][`X_BITS-1:0] in_pixels,
  input  wire logic [`COLS-1:0][`K_BITS-1:0] in_weights,
  output logic                               in_ready,
  output logic                               seq_valid,
  output logic                               seq_last,
  output logic [`ROWS-1:0][`X_BITS-1:0]      seq_pixels,
  output logic [`COLS-1:0][`K_BITS-1:0]      seq_weights,
  output cnn_pkg::tuser_st                   seq_user,
  input  wire logic                          eng_ready
);

  import cnn_pkg::*;

  // Largest half-width the array supports
  localparam logic [`KW2_BITS-1:0] KW2_LIMIT = `KW2_BITS'(`KW_MAX / 2);

  seq_state_e state;
  logic [`KW2_BITS-1:0] kw2_q;
  logic [`CIN_BITS-1:0] cin_q;
  logic [`CIN_BITS-1:0] beat_cnt;
  logic first_grp, cin_last, running, xfer;

  assign running   = (state == seq_run);
  assign in_ready  = running && eng_ready;
  assign seq_valid = running && in_valid;
  assign xfer      = seq_valid && eng_ready;
  assign cin_last  = (beat_cnt == cin_q - 1'b1);

  // Beat passes straight through
  assign seq_last    = in_last;
  assign seq_pixels  = in_pixels;
  assign seq_weights = in_weights;

  always_comb begin
    seq_user.kw2            = kw2_q;
    seq_user.is_cin_last    = cin_last;
    seq_user.is_w_first_clk = first_grp;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= seq_idle;
      kw2_q     <= '0;
      cin_q     <= '0;
      beat_cnt  <= '0;
      first_grp <= 1'b0;
    end else begin
      case (state)
        seq_idle: begin
          if (cfg_start) begin
            kw2_q     <= (cfg_kw2 > KW2_LIMIT) ? KW2_LIMIT : cfg_kw2;
            cin_q     <= cfg_cin;
            beat_cnt  <= '0;
            first_grp <= 1'b1;
            state     <= seq_run;
          end
        end
        seq_run: begin
          if (xfer) begin
            beat_cnt <= cin_last ? '0 : beat_cnt + 1'b1;
            if (cin_last) begin
              first_grp <= 1'b0;
            end
            // End of the weight set
            if (in_last) begin
              state <= seq_idle;
            end
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Array shape
`define COLS 4
`define ROWS 2

// Signed operand widths
`define X_BITS 8
`define K_BITS 8

// Accumulator holds X_BITS+K_BITS plus group growth
`define Y_BITS 20

// Register stages behind each multiplier
`define DELAY_MUL 2

// Kernel width limit and the half-width field
`define KW_MAX 3
`define KW2_BITS 2

// Input channel count field
`define CIN_BITS 4

`endif

// File: rtl/cnn_pkg.sv
`default_nettype none

`include "cnn_cfg.svh"

package cnn_pkg;

  // Side-band fields carried with every beat
  typedef struct packed {
    logic [`KW2_BITS-1:0] kw2;
    logic                 is_cin_last;
    logic                 is_w_first_clk;
  } tuser_st;

  localparam int TUSER_WIDTH = $bits(tuser_st);

  // Sequencer FSM
  typedef enum logic {
    seq_idle,
    seq_run
  } seq_state_e;

  // Serializer FSM
  typedef enum logic {
    ser_idle,
    ser_send
  } ser_state_e;

endpackage

`default_nettype wire

// File: rtl/column_serializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module column_serializer (
  input  wire logic                                  clk,
  input  wire logic                                  resetn,
  input  wire logic                                  s_valid,
  input  wire logic                                  s_last,
  input  wire logic [`COLS-1:0][`ROWS-1:0][`Y_BITS-1:0] s_data,
  output logic                                       s_ready,
  input  wire logic                                  out_ready,
  output logic                                       out_valid,
  output logic                                       out_last,
  output logic [$clog2(`COLS)-1:0]                   out_col,
  output logic [`ROWS-1:0][`Y_BITS-1:0]              out_data
);

  import cnn_pkg::*;

  localparam int COL_BITS = $clog2(`COLS);
  localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`COLS - 1);

  ser_state_e state;
  logic [COL_BITS-1:0] col;
  logic last_q;
  logic [`COLS-1:0][`ROWS-1:0][`Y_BITS-1:0] data_q;

  assign s_ready   = (state == ser_idle);
  assign out_valid = (state == ser_send);
  assign out_col   = col;
  assign out_data  = data_q[col];
  assign out_last  = last_q && (col == LAST_COL);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= ser_idle;
      col    <= '0;
      last_q <= 1'b0;
    end else begin
      case (state)
        ser_idle: begin
          if (s_valid) begin
            last_q <= s_last;
            col    <= '0;
            state  <= ser_send;
          end
        end
        ser_send: begin
          // Step one column per transfer
          if (out_ready) begin
            if (col == LAST_COL) begin
              col   <= '0;
              state <= ser_idle;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: state <= ser_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      data_q <= s_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_core (
  input  wire logic                          clk,
  input  wire logic                          resetn,
  input  wire logic                          cfg_start,
  input  wire logic [`KW2_BITS-1:0]          cfg_kw2,
  input  wire logic [`CIN_BITS-1:0]          cfg_cin,
  input  wire logic                          in_valid,
  output logic                               in_ready,
  input  wire logic                          in_last,
  input  wire logic [`ROWS-1:0][`X_BITS-1:0] in_pixels,
  input  wire logic [`COLS-1:0][`K_BITS-1:0] in_weights,
  input  wire logic                          out_ready,
  output logic                               out_valid,
  output logic                               out_last,
  output logic [$clog2(`COLS)-1:0]           out_col,
  output logic [`ROWS-1:0][`Y_BITS-1:0]      out_data
);

  import cnn_pkg::*;

  logic seq_valid, seq_last, eng_ready;
  logic [`ROWS-1:0][`X_BITS-1:0] seq_pixels;
  logic [`COLS-1:0][`K_BITS-1:0] seq_weights;
  tuser_st seq_user;
  logic eng_valid, eng_last, ser_ready;
  logic [`COLS-1:0][`ROWS-1:0][`Y_BITS-1:0] eng_data;

  beat_sequencer seq_i (
    .clk(clk), .resetn(resetn),
    .cfg_start(cfg_start), .cfg_kw2(cfg_kw2), .cfg_cin(cfg_cin),
    .in_valid(in_valid), .in_last(in_last), .in_pixels(in_pixels),
    .in_weights(in_weights), .in_ready(in_ready),
    .seq_valid(seq_valid), .seq_last(seq_last), .seq_pixels(seq_pixels),
    .seq_weights(seq_weights), .seq_user(seq_user), .eng_ready(eng_ready)
  );

  // Side-band output is not needed past the engine
  proc_engine eng_i (
    .clk(clk), .resetn(resetn),
    .s_ready(eng_ready), .s_valid(seq_valid), .s_last(seq_last),
    .s_data_pixels(seq_pixels), .s_data_weights(seq_weights), .s_user(seq_user),
    .m_ready(ser_ready), .m_valid(eng_valid), .m_last(eng_last),
    .m_data(eng_data), .m_user()
  );

  column_serializer ser_i (
    .clk(clk), .resetn(resetn),
    .s_valid(eng_valid), .s_last(eng_last), .s_data(eng_data), .s_ready(ser_ready),
    .out_ready(out_ready), .out_valid(out_valid), .out_last(out_last),
    .out_col(out_col), .out_data(out_data)
  );

endmodule

`default_nettype wire

// File: rtl/n_delay.sv
`timescale 1ns/100ps
`default_nettype none

module n_delay #(
  parameter int N = 1,
  parameter int W = 8
) (
  input  wire logic         c,
  input  wire logic         rn,
  input  wire logic         e,
  input  wire logic [W-1:0] i,
  output logic      [W-1:0] o
);

  if (N == 0) begin : g_wire
    assign o = i;
  end else begin : g_chain
    logic [N-1:0][W-1:0] stage;

    // Whole chain moves together on enable
    always_ff @(posedge c) begin
      if (!rn) begin
        stage <= '0;
      end else if (e) begin
        for (int k = N - 1; k > 0; k--) begin
          stage[k] <= stage[k-1];
        end
        stage[0] <= i;
      end
    end

    assign o = stage[N-1];
  end

endmodule

`default_nettype wire

// File: rtl/proc_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module proc_engine (
  input  wire logic                                  clk,
  input  wire logic                                  resetn,
  output logic                                       s_ready,
  input  wire logic                                  s_valid,
  input  wire logic                                  s_last,
  input  wire logic [`ROWS-1:0][`X_BITS-1:0]         s_data_pixels,
  input  wire logic [`COLS-1:0][`K_BITS-1:0]         s_data_weights,
  input  wire cnn_pkg::tuser_st                      s_user,
  input  wire logic                                  m_ready,
  output logic                                       m_valid,
  output logic                                       m_last,
  output logic [`COLS-1:0][`ROWS-1:0][`Y_BITS-1:0]   m_data,
  output cnn_pkg::tuser_st                           m_user
);

  import cnn_pkg::*;

  localparam int COLS   = `COLS;
  localparam int ROWS   = `ROWS;
  localparam int M_BITS = `X_BITS + `K_BITS;
  localparam int Y_BITS = `Y_BITS;
  localparam int KW2_N  = 1 << `KW2_BITS;

  logic en, clken_mul, acc_step, sel_shift, first_beat;
  logic mul_valid, mul_last, acc_valid, acc_last;
  tuser_st mul_user, acc_user;
  logic [TUSER_WIDTH+1:0] ctrl_in, ctrl_out;
  logic [COLS-1:0][KW2_N-1:0] start_lut;
  logic [COLS-1:0] col_start;
  logic [COLS-1:0][ROWS-1:0][M_BITS-1:0] prod, prod_d;
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] acc_data;

  // Output stall freezes everything, the shift cycle freezes the front
  assign en        = m_ready || !acc_valid;
  assign clken_mul = en && !sel_shift;
  assign s_ready   = clken_mul;
  assign acc_step  = clken_mul && mul_valid;

  assign ctrl_in = {s_valid, s_last, s_user};
  assign {mul_valid, mul_last, mul_user} = ctrl_out;

  n_delay #(.N(`DELAY_MUL), .W(TUSER_WIDTH + 2)) ctrl_dly (
    .c(clk), .rn(resetn), .e(clken_mul), .i(ctrl_in), .o(ctrl_out)
  );

  // One shift cycle after each group when kw2 is non-zero
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sel_shift  <= 1'b0;
      first_beat <= 1'b1;
    end else if (en) begin
      sel_shift <= acc_step && mul_user.is_cin_last && (mul_user.kw2 != '0);
      if (acc_step) begin
        first_beat <= mul_user.is_cin_last;
      end
    end
  end

  for (genvar c = 0; c < COLS; c++) begin : g_col
    // Kernel start columns per half-width
    for (genvar k = 0; k < KW2_N; k++) begin : g_lut
      assign start_lut[c][k] = (c % (2 * k + 1)) == 0;
    end
    assign col_start[c] = start_lut[c][mul_user.kw2];

    for (genvar r = 0; r < ROWS; r++) begin : g_row
      logic signed [Y_BITS-1:0] prod_ext, acc_base, left_sum, carry_q;

      assign prod[c][r] = $signed(s_data_pixels[r]) * $signed(s_data_weights[c]);

      n_delay #(.N(`DELAY_MUL), .W(M_BITS)) mul_dly (
        .c(clk), .rn(1'b1), .e(clken_mul), .i(prod[c][r]), .o(prod_d[c][r])
      );

      assign prod_ext = {{(Y_BITS - M_BITS){prod_d[c][r][M_BITS-1]}}, prod_d[c][r]};

      if (c == 0) begin : g_edge
        assign left_sum = '0;
      end else begin : g_inner
        assign left_sum = acc_data[c-1][r];
      end

      // Group starts from the carry unless first group or kernel start
      always_comb begin
        if (!first_beat) begin
          acc_base = acc_data[c][r];
        end else if (mul_user.is_w_first_clk || col_start[c]) begin
          acc_base = '0;
        end else begin
          acc_base = carry_q;
        end
      end

      always_ff @(posedge clk) begin
        if (acc_step) begin
          acc_data[c][r] <= acc_base + prod_ext;
        end
        if (en && sel_shift && !col_start[c]) begin
          carry_q <= left_sum;
        end
      end
    end
  end

  // Result register, one beat per group
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
    end else if (en) begin
      acc_valid <= acc_step && mul_user.is_cin_last;
      acc_last  <= acc_step && mul_user.is_cin_last && mul_last;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_step) begin
      acc_user <= mul_user;
    end
  end

  assign m_valid = acc_valid;
  assign m_last  = acc_last;
  assign m_data  = acc_data;
  assign m_user  = acc_user;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the conv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module conv_core_tb \
  -f conv_core.f -o conv_core_sim \
  && ./obj_dir/conv_core_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error status" >> sim.log
cat sim.log
if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
  exit 1
fi
exit 0
